// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 16;
    localparam int WORDS_PER_LINE = 4;

    localparam int BYTE_W = 2;
    localparam int BYTES_PER_WORD = WORD_W / 8;
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int SET_W = $clog2(NUM_SETS);
    localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);
    localparam int TAG_W = ADDR_W - SET_W - WORD_IDX_W - BYTE_W;

    // address field positions
    localparam int WORD_LSB = BYTE_W;
    localparam int SET_LSB = WORD_LSB + WORD_IDX_W;
    localparam int TAG_LSB = SET_LSB + SET_W;

    typedef enum logic [1:0] {
        LINE_INVALID = 2'b00,
        LINE_CLEAN   = 2'b01,
        LINE_DIRTY   = 2'b10
    } line_state_e;

    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } load_req_t;

    typedef struct packed {
        logic              valid;
        logic              hit;
        logic              conflict;
        logic [WORD_W-1:0] data;
    } load_resp_t;

    typedef struct packed {
        logic                      valid;
        logic [ADDR_W-1:0]         addr;
        logic [WORD_W-1:0]         data;
        logic [BYTES_PER_WORD-1:0] mask;
    } store_req_t;

    typedef struct packed {
        logic valid;
        logic hit;
    } store_resp_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [WAY_W-1:0]  way;
        line_t             line;
    } refill_req_t;

    // addr is the line base of the victim
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        line_t             line;
    } evict_t;

    typedef struct packed {
        logic                      en;
        logic [SET_W-1:0]          set;
        logic [WAY_W-1:0]          way;
        logic [WORD_IDX_W-1:0]     word_idx;
        logic [WORD_W-1:0]         data;
        logic [BYTES_PER_WORD-1:0] mask;
    } store_wr_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        line_state_e      state;
    } tag_entry_t;

    function automatic logic [WORD_W-1:0] merge_bytes(
        input logic [WORD_W-1:0]         old_word,
        input logic [WORD_W-1:0]         new_word,
        input logic [BYTES_PER_WORD-1:0] mask
    );
        logic [WORD_W-1:0] result;
        result = old_word;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/dcache_arrays.sv ====
`default_nettype none

module dcache_arrays #(
    parameter int NUM_WAYS = dcache_pkg::NUM_WAYS,
    parameter int NUM_SETS = dcache_pkg::NUM_SETS,
    parameter int WORDS_PER_LINE = dcache_pkg::WORDS_PER_LINE,
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
    localparam int WORD_BITS = $clog2(WORDS_PER_LINE)
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [SET_BITS-1:0]                         ld_set,
    input  logic [WORD_BITS-1:0]                        ld_word,
    output dcache_pkg::tag_entry_t [NUM_WAYS-1:0]       ld_tags,
    output logic [NUM_WAYS-1:0][dcache_pkg::WORD_W-1:0] ld_words,
    input  logic [SET_BITS-1:0]                         st_set,
    output dcache_pkg::tag_entry_t [NUM_WAYS-1:0]       st_tags,
    input  dcache_pkg::store_wr_t                       st_wr,
    input  logic                                        rf_en,
    input  logic [SET_BITS-1:0]                         rf_set,
    input  logic [WAY_BITS-1:0]                         rf_way,
    input  logic [dcache_pkg::TAG_W-1:0]                rf_tag,
    input  dcache_pkg::line_t                           rf_line,
    output dcache_pkg::tag_entry_t                      rf_old_tag,
    output dcache_pkg::line_t                           rf_old_line
);
    import dcache_pkg::*;

    line_state_e      state_q [NUM_SETS][NUM_WAYS];
    logic [TAG_W-1:0] tag_q [NUM_SETS][NUM_WAYS];
    line_t            data_q [NUM_SETS][NUM_WAYS];

    tag_entry_t [NUM_WAYS-1:0] st_view;
    tag_entry_t                rf_view_tag;
    line_t                     rf_view_line;
    logic                      st_hits_rf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    state_q[s][w] <= LINE_INVALID;
                end
            end
        end else begin
            if (st_wr.en) begin
                state_q[st_wr.set][st_wr.way] <= LINE_DIRTY;
            end
            // refill comes last so it wins on a shared entry
            if (rf_en) begin
                state_q[rf_set][rf_way] <= LINE_CLEAN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_wr.en) begin
            data_q[st_wr.set][st_wr.way][st_wr.word_idx] <=
                merge_bytes(data_q[st_wr.set][st_wr.way][st_wr.word_idx], st_wr.data, st_wr.mask);
        end
        if (rf_en) begin
            tag_q[rf_set][rf_way] <= rf_tag;
            data_q[rf_set][rf_way] <= rf_line;
        end
    end

    // store lookup sees this cycle's refill, so a store right after it hits
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            st_view[w].tag = tag_q[st_set][w];
            st_view[w].state = state_q[st_set][w];
            if (rf_en && (rf_set == st_set) && (rf_way == w)) begin
                st_view[w].tag = rf_tag;
                st_view[w].state = LINE_CLEAN;
            end
        end
    end

    // victim includes a store landing on it in the same cycle
    assign st_hits_rf = st_wr.en && (st_wr.set == rf_set) && (st_wr.way == rf_way);

    always_comb begin
        rf_view_tag.tag = tag_q[rf_set][rf_way];
        rf_view_tag.state = state_q[rf_set][rf_way];
        rf_view_line = data_q[rf_set][rf_way];
        if (st_hits_rf) begin
            rf_view_tag.state = LINE_DIRTY;
            rf_view_line[st_wr.word_idx] =
                merge_bytes(rf_view_line[st_wr.word_idx], st_wr.data, st_wr.mask);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            ld_tags[w] <= '{tag: tag_q[ld_set][w], state: state_q[ld_set][w]};
            ld_words[w] <= data_q[ld_set][w][ld_word];
        end
        st_tags <= st_view;
        rf_old_tag <= rf_view_tag;
        rf_old_line <= rf_view_line;
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_load_pipe.sv ====
`default_nettype none

module dcache_load_pipe #(
    parameter int NUM_WAYS = dcache_pkg::NUM_WAYS,
    parameter int WORDS_PER_LINE = dcache_pkg::WORDS_PER_LINE,
    localparam int WORD_BITS = $clog2(WORDS_PER_LINE)
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  dcache_pkg::load_req_t                       req,
    input  dcache_pkg::store_wr_t                       st_wr,
    input  logic                                        refill_valid,
    output logic [dcache_pkg::SET_W-1:0]                ld_set,
    output logic [WORD_BITS-1:0]                        ld_word,
    input  dcache_pkg::tag_entry_t [NUM_WAYS-1:0]       ld_tags,
    input  logic [NUM_WAYS-1:0][dcache_pkg::WORD_W-1:0] ld_words,
    output dcache_pkg::load_resp_t                      resp
);
    import dcache_pkg::*;

    logic             s1_valid;
    logic             s1_conflict;
    logic [TAG_W-1:0] s1_tag;
    logic             conflict;

    logic [NUM_WAYS-1:0] way_hit;
    logic [WORD_W-1:0]   hit_word;
    logic                any_hit;

    logic              resp_valid_q;
    logic              resp_hit_q;
    logic              resp_conflict_q;
    logic [WORD_W-1:0] resp_data_q;

    assign ld_set = req.addr[SET_LSB +: SET_W];
    assign ld_word = req.addr[WORD_LSB +: WORD_BITS];

    // any refill, or a store write into the set being read
    assign conflict = refill_valid | (st_wr.en & (st_wr.set == ld_set));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag <= req.addr[TAG_LSB +: TAG_W];
        s1_conflict <= conflict;
    end

    // stage two compares against the registered array read
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = (ld_tags[w].state != LINE_INVALID) && (ld_tags[w].tag == s1_tag);
            if (way_hit[w]) begin
                hit_word = ld_words[w];
            end
        end
    end

    assign any_hit = |way_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        resp_hit_q <= any_hit & ~s1_conflict;
        resp_conflict_q <= s1_conflict;
        resp_data_q <= hit_word;
    end

    assign resp = '{
        valid:    resp_valid_q,
        hit:      resp_hit_q,
        conflict: resp_conflict_q,
        data:     resp_data_q
    };

endmodule

`default_nettype wire

// ==== rtl/dcache_store_pipe.sv ====
`default_nettype none

module dcache_store_pipe #(
    parameter int NUM_WAYS = dcache_pkg::NUM_WAYS,
    parameter int WORDS_PER_LINE = dcache_pkg::WORDS_PER_LINE,
    localparam int WORD_BITS = $clog2(WORDS_PER_LINE)
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  dcache_pkg::store_req_t                req,
    output logic [dcache_pkg::SET_W-1:0]          st_set,
    input  dcache_pkg::tag_entry_t [NUM_WAYS-1:0] st_tags,
    output dcache_pkg::store_wr_t                 st_wr,
    output dcache_pkg::store_resp_t               resp
);
    import dcache_pkg::*;

    logic                      s1_valid;
    logic [ADDR_W-1:0]         s1_addr;
    logic [WORD_W-1:0]         s1_data;
    logic [BYTES_PER_WORD-1:0] s1_mask;

    logic [NUM_WAYS-1:0] way_hit;
    logic [WAY_W-1:0]    hit_way;
    logic                hit;

    logic resp_valid_q;
    logic resp_hit_q;

    assign st_set = req.addr[SET_LSB +: SET_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= req.addr;
        s1_data <= req.data;
        s1_mask <= req.mask;
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = (st_tags[w].state != LINE_INVALID) &&
                         (st_tags[w].tag == s1_addr[TAG_LSB +: TAG_W]);
            if (way_hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit = |way_hit;

    // write goes out in the lookup cycle, array takes it at the next edge
    assign st_wr = '{
        en:       s1_valid & hit,
        set:      s1_addr[SET_LSB +: SET_W],
        way:      hit_way,
        word_idx: s1_addr[WORD_LSB +: WORD_BITS],
        data:     s1_data,
        mask:     s1_mask
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        resp_hit_q <= hit;
    end

    assign resp = '{valid: resp_valid_q, hit: resp_hit_q};

endmodule

`default_nettype wire

// ==== rtl/dcache_refill_ctrl.sv ====
`default_nettype none

module dcache_refill_ctrl #(
    parameter int NUM_WAYS = dcache_pkg::NUM_WAYS,
    parameter int NUM_SETS = dcache_pkg::NUM_SETS,
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  dcache_pkg::refill_req_t      req,
    output logic                         rf_en,
    output logic [SET_BITS-1:0]          rf_set,
    output logic [WAY_BITS-1:0]          rf_way,
    output logic [dcache_pkg::TAG_W-1:0] rf_tag,
    output dcache_pkg::line_t            rf_line,
    input  dcache_pkg::tag_entry_t       rf_old_tag,
    input  dcache_pkg::line_t            rf_old_line,
    output dcache_pkg::evict_t           evict
);
    import dcache_pkg::*;

    logic                s1_valid;
    logic [SET_BITS-1:0] s1_set;
    logic                victim_dirty;

    logic              evict_valid_q;
    logic [ADDR_W-1:0] evict_addr_q;
    line_t             evict_line_q;

    // refill is written at the end of its request cycle
    assign rf_en = req.valid;
    assign rf_set = req.addr[SET_LSB +: SET_BITS];
    assign rf_way = req.way;
    assign rf_tag = req.addr[TAG_LSB +: TAG_W];
    assign rf_line = req.line;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_set <= rf_set;
    end

    // old entry arrives one cycle after the refill
    assign victim_dirty = s1_valid & (rf_old_tag.state == LINE_DIRTY);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            evict_valid_q <= 1'b0;
        end else begin
            evict_valid_q <= victim_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (victim_dirty) begin
            evict_addr_q <= {rf_old_tag.tag, s1_set, {SET_LSB{1'b0}}};
            evict_line_q <= rf_old_line;
        end
    end

    assign evict = '{
        valid: evict_valid_q,
        addr:  evict_addr_q,
        line:  evict_line_q
    };

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`default_nettype none

module dcache_top #(
    parameter int NUM_WAYS = dcache_pkg::NUM_WAYS,
    parameter int NUM_SETS = dcache_pkg::NUM_SETS,
    parameter int WORDS_PER_LINE = dcache_pkg::WORDS_PER_LINE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  dcache_pkg::load_req_t   load_req,
    input  dcache_pkg::store_req_t  store_req,
    input  dcache_pkg::refill_req_t refill_req,
    output dcache_pkg::load_resp_t  load_resp,
    output dcache_pkg::store_resp_t store_resp,
    output dcache_pkg::evict_t      evict
);
    import dcache_pkg::*;

    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int WORD_BITS = $clog2(WORDS_PER_LINE);

    // load read port
    logic [SET_W-1:0]                  ld_set;
    logic [WORD_BITS-1:0]              ld_word;
    tag_entry_t [NUM_WAYS-1:0]         ld_tags;
    logic [NUM_WAYS-1:0][WORD_W-1:0]   ld_words;

    // store lookup and write
    logic [SET_W-1:0]          st_set;
    tag_entry_t [NUM_WAYS-1:0] st_tags;
    store_wr_t                 st_wr;

    // refill write and victim read
    logic                rf_en;
    logic [SET_BITS-1:0] rf_set;
    logic [WAY_BITS-1:0] rf_way;
    logic [TAG_W-1:0]    rf_tag;
    line_t               rf_line;
    tag_entry_t          rf_old_tag;
    line_t               rf_old_line;

    dcache_arrays #(
        .NUM_WAYS       (NUM_WAYS),
        .NUM_SETS       (NUM_SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) u_arrays (
        .clk         (clk),
        .rst         (rst),
        .ld_set      (ld_set),
        .ld_word     (ld_word),
        .ld_tags     (ld_tags),
        .ld_words    (ld_words),
        .st_set      (st_set),
        .st_tags     (st_tags),
        .st_wr       (st_wr),
        .rf_en       (rf_en),
        .rf_set      (rf_set),
        .rf_way      (rf_way),
        .rf_tag      (rf_tag),
        .rf_line     (rf_line),
        .rf_old_tag  (rf_old_tag),
        .rf_old_line (rf_old_line)
    );

    dcache_load_pipe #(
        .NUM_WAYS       (NUM_WAYS),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) u_load_pipe (
        .clk          (clk),
        .rst          (rst),
        .req          (load_req),
        .st_wr        (st_wr),
        .refill_valid (refill_req.valid),
        .ld_set       (ld_set),
        .ld_word      (ld_word),
        .ld_tags      (ld_tags),
        .ld_words     (ld_words),
        .resp         (load_resp)
    );

    dcache_store_pipe #(
        .NUM_WAYS       (NUM_WAYS),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) u_store_pipe (
        .clk     (clk),
        .rst     (rst),
        .req     (store_req),
        .st_set  (st_set),
        .st_tags (st_tags),
        .st_wr   (st_wr),
        .resp    (store_resp)
    );

    dcache_refill_ctrl #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) u_refill_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (refill_req),
        .rf_en       (rf_en),
        .rf_set      (rf_set),
        .rf_way      (rf_way),
        .rf_tag      (rf_tag),
        .rf_line     (rf_line),
        .rf_old_tag  (rf_old_tag),
        .rf_old_line (rf_old_line),
        .evict       (evict)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/dcache_tb.sv ====
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int RESP_TIMEOUT = 8;
    localparam int RANDOM_CYCLES = 2000;
    localparam int TAG_BASE = 'h0a0;

    logic        clk;
    logic        rst;
    load_req_t   load_req;
    store_req_t  store_req;
    refill_req_t refill_req;
    load_resp_t  load_resp;
    store_resp_t store_resp;
    evict_t      evict;

    integer seed;
    string  test_name;
    int     cyc;

    // reference model of the cache contents
    logic [TAG_W-1:0] m_tag [NUM_SETS][NUM_WAYS];
    line_state_e      m_state [NUM_SETS][NUM_WAYS];
    line_t            m_line [NUM_SETS][NUM_WAYS];
    store_wr_t        pend_wr;

    load_resp_t  load_exp_q[$];
    int          load_due_q[$];
    string       load_name_q[$];
    store_resp_t store_exp_q[$];
    int          store_due_q[$];
    string       store_name_q[$];
    evict_t      evict_exp_q[$];
    int          evict_due_q[$];
    string       evict_name_q[$];

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(16)) u_clock_gen (.clk(clk), .rst(rst));

    dcache_top #(
        .NUM_WAYS       (NUM_WAYS),
        .NUM_SETS       (NUM_SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .load_req   (load_req),
        .store_req  (store_req),
        .refill_req (refill_req),
        .load_resp  (load_resp),
        .store_resp (store_resp),
        .evict      (evict)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic int addr_set(input logic [ADDR_W-1:0] addr);
        return int'(addr[SET_LSB +: SET_W]);
    endfunction

    function automatic int addr_word(input logic [ADDR_W-1:0] addr);
        return int'(addr[WORD_LSB +: WORD_IDX_W]);
    endfunction

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[TAG_LSB +: TAG_W];
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int word);
        return (ADDR_W'(tag) << TAG_LSB) | (ADDR_W'(set) << SET_LSB) | (ADDR_W'(word) << WORD_LSB);
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        int tag;
        int set;
        int word;
        tag = TAG_BASE + int'($unsigned($random(seed)) % 4);
        set = int'($unsigned($random(seed)) % 8);
        word = int'($unsigned($random(seed)) % WORDS_PER_LINE);
        return make_addr(tag, set, word);
    endfunction

    function automatic line_t fill_line(input logic [ADDR_W-1:0] addr);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i] = ((addr | (i << WORD_LSB)) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    // reuse the way that already holds the tag, so no set has a tag twice
    function automatic logic [WAY_W-1:0] pick_way(input logic [ADDR_W-1:0] addr, input logic rnd);
        logic [WAY_W-1:0] way;
        way = WAY_W'(rnd);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_state[addr_set(addr)][w] != LINE_INVALID &&
                m_tag[addr_set(addr)][w] == addr_tag(addr)) begin
                way = WAY_W'(w);
            end
        end
        return way;
    endfunction

    // byte enables widened to a bit mask
    function automatic logic [WORD_W-1:0] apply_mask(input logic [WORD_W-1:0] old_word,
                                                     input logic [WORD_W-1:0] new_word,
                                                     input logic [BYTES_PER_WORD-1:0] mask);
        logic [WORD_W-1:0] keep;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            keep[8*b +: 8] = {8{mask[b]}};
        end
        return (old_word & ~keep) | (new_word & keep);
    endfunction

    function automatic load_resp_t ref_load(input logic [ADDR_W-1:0] addr, input logic conflict);
        load_resp_t r;
        int s;
        r = '0;
        s = addr_set(addr);
        r.valid = 1'b1;
        r.conflict = conflict;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!conflict && m_state[s][w] != LINE_INVALID && m_tag[s][w] == addr_tag(addr)) begin
                r.hit = 1'b1;
                r.data = m_line[s][w][addr_word(addr)];
            end
        end
        return r;
    endfunction

    function automatic logic ref_store_lookup(input logic [ADDR_W-1:0] addr, output int way);
        logic hit;
        int s;
        hit = 1'b0;
        way = 0;
        s = addr_set(addr);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_state[s][w] != LINE_INVALID && m_tag[s][w] == addr_tag(addr)) begin
                hit = 1'b1;
                way = w;
            end
        end
        return hit;
    endfunction

    function automatic evict_t ref_victim(input int s, input int w);
        evict_t ev;
        ev = '0;
        if (m_state[s][w] == LINE_DIRTY) begin
            ev.valid = 1'b1;
            ev.addr = make_addr(int'(m_tag[s][w]), s, 0);
            ev.line = m_line[s][w];
        end
        return ev;
    endfunction

    task automatic check_load(input string name, input load_resp_t exp, input load_resp_t act);
        if (act.hit !== exp.hit || act.conflict !== exp.conflict ||
            (exp.hit && act.data !== exp.data)) begin
            abort_run($sformatf("FAILED %s load_resp: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_store(input string name, input store_resp_t exp, input store_resp_t act);
        if (act.hit !== exp.hit) begin
            abort_run($sformatf("FAILED %s store_resp: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_evict(input string name, input evict_t exp, input evict_t act);
        if (act.addr !== exp.addr || act.line !== exp.line) begin
            abort_run($sformatf("FAILED %s evict: expected %h actual %h", name, exp, act));
        end
    endtask

    // model update at each edge, in the order the arrays apply writes
    always @(posedge clk) begin : model_step
        logic   conflict;
        logic   hit;
        int     s;
        int     w;
        int     hit_way;
        evict_t ev;
        store_resp_t sr;
        if (rst) begin
            pend_wr = '0;
            cyc = 0;
            for (int i = 0; i < NUM_SETS; i++) begin
                for (int j = 0; j < NUM_WAYS; j++) m_state[i][j] = LINE_INVALID;
            end
        end else begin
            if (load_req.valid) begin
                conflict = refill_req.valid ||
                           (pend_wr.en && pend_wr.set == addr_set(load_req.addr));
                load_exp_q.push_back(ref_load(load_req.addr, conflict));
                load_due_q.push_back(cyc + 2);
                load_name_q.push_back(test_name);
            end
            if (pend_wr.en) begin
                m_line[pend_wr.set][pend_wr.way][pend_wr.word_idx] = apply_mask(
                    m_line[pend_wr.set][pend_wr.way][pend_wr.word_idx], pend_wr.data, pend_wr.mask);
                m_state[pend_wr.set][pend_wr.way] = LINE_DIRTY;
            end
            if (refill_req.valid) begin
                s = addr_set(refill_req.addr);
                w = int'(refill_req.way);
                ev = ref_victim(s, w);
                if (ev.valid) begin
                    evict_exp_q.push_back(ev);
                    evict_due_q.push_back(cyc + 2);
                    evict_name_q.push_back(test_name);
                end
                m_tag[s][w] = addr_tag(refill_req.addr);
                m_state[s][w] = LINE_CLEAN;
                m_line[s][w] = refill_req.line;
            end
            pend_wr = '0;
            // lookup sees this cycle's refill
            if (store_req.valid) begin
                hit = ref_store_lookup(store_req.addr, hit_way);
                sr.valid = 1'b1;
                sr.hit = hit;
                store_exp_q.push_back(sr);
                store_due_q.push_back(cyc + 2);
                store_name_q.push_back(test_name);
                pend_wr.en = hit;
                pend_wr.set = SET_W'(addr_set(store_req.addr));
                pend_wr.way = WAY_W'(hit_way);
                pend_wr.word_idx = WORD_IDX_W'(addr_word(store_req.addr));
                pend_wr.data = store_req.data;
                pend_wr.mask = store_req.mask;
            end
            cyc = cyc + 1;
        end
    end

    // outputs settle after the edge, sample mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (load_resp.valid) begin
                if (load_due_q.size() == 0 || load_due_q[0] != cyc) begin
                    abort_run("load response valid in a cycle where none was expected");
                end
                load_due_q.delete(0);
                check_load(load_name_q.pop_front(), load_exp_q.pop_front(), load_resp);
            end else if (load_due_q.size() > 0 && cyc > load_due_q[0] + RESP_TIMEOUT) begin
                abort_run("expected load response never arrived");
            end
            if (store_resp.valid) begin
                if (store_due_q.size() == 0 || store_due_q[0] != cyc) begin
                    abort_run("store response valid in a cycle where none was expected");
                end
                store_due_q.delete(0);
                check_store(store_name_q.pop_front(), store_exp_q.pop_front(), store_resp);
            end else if (store_due_q.size() > 0 && cyc > store_due_q[0] + RESP_TIMEOUT) begin
                abort_run("expected store response never arrived");
            end
            if (evict.valid) begin
                if (evict_due_q.size() == 0 || evict_due_q[0] != cyc) begin
                    abort_run("evict valid in a cycle where no dirty victim was expected");
                end
                evict_due_q.delete(0);
                check_evict(evict_name_q.pop_front(), evict_exp_q.pop_front(), evict);
            end else if (evict_due_q.size() > 0 && cyc > evict_due_q[0] + RESP_TIMEOUT) begin
                abort_run("expected evict never arrived");
            end
        end
    end

    task automatic step(input load_req_t ld, input store_req_t st, input refill_req_t rf);
        load_req = ld;
        store_req = st;
        refill_req = rf;
        @(posedge clk);
        #1;
    endtask

    task automatic idle();
        step('0, '0, '0);
    endtask

    task automatic do_load(input logic [ADDR_W-1:0] addr);
        step('{valid: 1'b1, addr: addr}, '0, '0);
    endtask

    task automatic do_store(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                            input logic [BYTES_PER_WORD-1:0] mask);
        step('0, '{valid: 1'b1, addr: addr, data: data, mask: mask}, '0);
    endtask

    task automatic do_refill(input logic [ADDR_W-1:0] addr, input int way);
        step('0, '0, '{valid: 1'b1, addr: addr, way: WAY_W'(way), line: fill_line(addr)});
    endtask

    function automatic int pending_count();
        return load_due_q.size() + store_due_q.size() + evict_due_q.size();
    endfunction

    initial begin
        logic [31:0] r;
        load_req_t   ld;
        store_req_t  st;
        refill_req_t rf;
        int          wait_cnt;
        seed = 32'h28d9;
        test_name = "reset";
        load_req = '0;
        store_req = '0;
        refill_req = '0;
        wait_cnt = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 100) abort_run("reset was never released");
        end
        #1;

        test_name = "refill_then_load";
        do_refill(make_addr('h0a1, 3, 0), 0);
        do_refill(make_addr('h0b1, 3, 0), 1);
        for (int i = 0; i < WORDS_PER_LINE; i++) do_load(make_addr('h0a1, 3, i));
        do_load(make_addr('h0a2, 3, 0));

        test_name = "store_hit_merge";
        do_store(make_addr('h0a1, 3, 1), 32'h1122_3344, 4'b0101);
        idle();
        do_load(make_addr('h0a1, 3, 1));

        test_name = "store_miss";
        do_store(make_addr('h0a2, 3, 2), 32'hdead_beef, 4'b1111);
        idle();
        do_load(make_addr('h0a2, 3, 2));
        do_load(make_addr('h0a1, 3, 2));

        // dirty, then clean, then invalid victim
        test_name = "refill_evict";
        do_refill(make_addr('h0c1, 3, 0), 0);
        idle();
        do_refill(make_addr('h0c2, 3, 0), 0);
        do_refill(make_addr('h0d1, 5, 0), 1);
        idle();

        test_name = "load_conflict";
        step('{valid: 1'b1, addr: make_addr('h0c2, 3, 0)}, '0,
             '{valid: 1'b1, addr: make_addr('h0e1, 6, 0), way: '0,
               line: fill_line(make_addr('h0e1, 6, 0))});
        do_store(make_addr('h0c2, 3, 1), 32'hcafe_f00d, 4'b1111);
        do_load(make_addr('h0c2, 3, 1));
        do_store(make_addr('h0e1, 6, 2), 32'h0bad_cafe, 4'b0011);
        do_load(make_addr('h0c2, 3, 1));
        idle();

        test_name = "random_traffic";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = $random(seed);
            ld = '0;
            st = '0;
            rf = '0;
            ld.valid = r[0] | r[1];
            ld.addr = rand_addr();
            st.valid = r[2];
            st.addr = rand_addr();
            st.data = $random(seed);
            st.mask = r[7:4];
            rf.valid = r[8] & r[9];
            rf.addr = rand_addr();
            rf.way = pick_way(rf.addr, r[10]);
            for (int i = 0; i < WORDS_PER_LINE; i++) rf.line[i] = $random(seed);
            step(ld, st, rf);
        end

        test_name = "drain";
        wait_cnt = 0;
        while (pending_count() > 0 && wait_cnt < 20) begin
            idle();
            wait_cnt++;
        end
        if (pending_count() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("responses still outstanding when the run ended");
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/dcache_pkg.sv
rtl/dcache_arrays.sv
rtl/dcache_load_pipe.sv
rtl/dcache_store_pipe.sv
rtl/dcache_refill_ctrl.sv
rtl/dcache_top.sv
verif/tb_clock_gen.sv
verif/dcache_tb.sv
